// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// byte address as seen by the clients and the bus
	typedef logic [31:0] addr_t;

	// one sram word
	typedef logic [63:0] data_t;

	// one enable bit per data byte
	typedef logic [7:0] strb_t;

	// axi-lite response code
	typedef logic [1:0] resp_t;

	// only okay and slave error are ever returned
	localparam resp_t resp_okay   = 2'd0;
	localparam resp_t resp_slverr = 2'd2;

	// bytes per word, byte address to word index
	localparam int word_bytes = 8;

endpackage

`default_nettype wire

// ==== axi_lite_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_if import mem_pkg::*; ();

	// read address channel
	logic  arvalid;
	logic  arready;
	addr_t araddr;

	// read data channel
	logic  rvalid;
	logic  rready;
	data_t rdata;
	resp_t rresp;

	// write address channel
	logic  awvalid;
	logic  awready;
	addr_t awaddr;

	// write data channel
	logic  wvalid;
	logic  wready;
	data_t wdata;
	strb_t wstrb;

	// write response channel
	logic  bvalid;
	logic  bready;
	resp_t bresp;

	// requester side
	modport master (
		output arvalid, araddr, rready,
		output awvalid, awaddr, wvalid, wdata, wstrb, bready,
		input  arready, rvalid, rdata, rresp,
		input  awready, wready, bvalid, bresp
	);

	// responder side, mirror of master
	modport slave (
		input  arvalid, araddr, rready,
		input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
		output arready, rvalid, rdata, rresp,
		output awready, wready, bvalid, bresp
	);

endinterface

`default_nettype wire

// ==== mem_client_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_client_bridge import mem_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      req,
	input  logic      we,
	input  addr_t     addr,
	input  data_t     wdata,
	input  strb_t     wstrb,
	output logic      busy,
	output logic      resp_valid,
	output data_t     rdata,
	output logic      err,
	axi_lite_if.master bus
);

	typedef enum logic [1:0] {
		idle,
		addr_phase,
		resp_phase
	} state_t;

	state_t state;

	// captured request
	logic  we_q;
	addr_t addr_q;
	data_t wdata_q;
	strb_t wstrb_q;

	// handshake events
	logic addr_done;
	logic resp_done;

	// aw and w go out together and complete together
	assign addr_done = we_q ? (bus.awvalid && bus.awready && bus.wvalid && bus.wready)
	                        : (bus.arvalid && bus.arready);
	assign resp_done = we_q ? (bus.bvalid && bus.bready)
	                        : (bus.rvalid && bus.rready);

	// only one channel pair is active per transaction
	assign bus.arvalid = (state == addr_phase) && !we_q;
	assign bus.awvalid = (state == addr_phase) && we_q;
	assign bus.wvalid  = (state == addr_phase) && we_q;
	assign bus.araddr  = addr_q;
	assign bus.awaddr  = addr_q;
	assign bus.wdata   = wdata_q;
	assign bus.wstrb   = wstrb_q;

	// always ready for the response once a transfer is under way
	assign bus.rready = (state != idle) && !we_q;
	assign bus.bready = (state != idle) && we_q;

	// low again in the cycle of the result pulse
	assign busy = (state != idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= idle;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			case (state)
				idle: begin
					if (req) begin
						state <= addr_phase;
					end
				end
				addr_phase: begin
					// waits here while the arbiter holds ready low
					if (addr_done) begin
						state <= resp_phase;
					end
				end
				resp_phase: begin
					if (resp_done) begin
						state      <= idle;
						resp_valid <= 1'b1;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// request payload, sampled only from idle
	always_ff @(posedge clk) begin
		if (state == idle && req) begin
			we_q    <= we;
			addr_q  <= addr;
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
	end

	// result word and error flag for the pulse
	always_ff @(posedge clk) begin
		if (state == resp_phase && resp_done) begin
			rdata <= we_q ? '0 : bus.rdata;
			err   <= (we_q ? bus.bresp : bus.rresp) == resp_slverr;
		end
	end

	// client must wait for busy to drop
	a_no_req_busy: assert property (@(posedge clk) disable iff (rst) req |-> !busy)
		else $error("bridge: req while busy");

endmodule

`default_nettype wire

// ==== axi_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rr_arbiter (
	input  logic       clk,
	input  logic       rst,
	axi_lite_if.slave  m_a,
	axi_lite_if.slave  m_b,
	axi_lite_if.master s
);

	// registered grant with bit 0 for a and bit 1 for b
	logic [1:0] gnt;

	// bus held by a bridge until its response completes
	logic owned;

	// b was the last bridge granted
	logic last_b;

	logic req_a;
	logic req_b;
	logic pick_a;
	logic pick_b;
	logic sel_a;
	logic sel_b;
	logic rel;

	// a request is any address valid
	assign req_a = m_a.arvalid || m_a.awvalid;
	assign req_b = m_b.arvalid || m_b.awvalid;

	// round robin on a tie
	assign pick_a = req_a && (!req_b || last_b);
	assign pick_b = req_b && !pick_a;

	// free bus routes in the request cycle itself
	assign sel_a = owned ? gnt[0] : pick_a;
	assign sel_b = owned ? gnt[1] : pick_b;

	// owner's response handshake frees the bus
	assign rel = owned && ((s.rvalid && s.rready) || (s.bvalid && s.bready));

	// request channels to the sram
	assign s.arvalid = (sel_a && m_a.arvalid) || (sel_b && m_b.arvalid);
	assign s.araddr  = sel_b ? m_b.araddr : m_a.araddr;
	assign s.rready  = (sel_a && m_a.rready) || (sel_b && m_b.rready);
	assign s.awvalid = (sel_a && m_a.awvalid) || (sel_b && m_b.awvalid);
	assign s.awaddr  = sel_b ? m_b.awaddr : m_a.awaddr;
	assign s.wvalid  = (sel_a && m_a.wvalid) || (sel_b && m_b.wvalid);
	assign s.wdata   = sel_b ? m_b.wdata : m_a.wdata;
	assign s.wstrb   = sel_b ? m_b.wstrb : m_a.wstrb;
	assign s.bready  = (sel_a && m_a.bready) || (sel_b && m_b.bready);

	// back to bridge a and zero when not granted
	assign m_a.arready = sel_a && s.arready;
	assign m_a.rvalid  = sel_a && s.rvalid;
	assign m_a.rdata   = sel_a ? s.rdata : '0;
	assign m_a.rresp   = sel_a ? s.rresp : '0;
	assign m_a.awready = sel_a && s.awready;
	assign m_a.wready  = sel_a && s.wready;
	assign m_a.bvalid  = sel_a && s.bvalid;
	assign m_a.bresp   = sel_a ? s.bresp : '0;

	// back to bridge b
	assign m_b.arready = sel_b && s.arready;
	assign m_b.rvalid  = sel_b && s.rvalid;
	assign m_b.rdata   = sel_b ? s.rdata : '0;
	assign m_b.rresp   = sel_b ? s.rresp : '0;
	assign m_b.awready = sel_b && s.awready;
	assign m_b.wready  = sel_b && s.wready;
	assign m_b.bvalid  = sel_b && s.bvalid;
	assign m_b.bresp   = sel_b ? s.bresp : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			gnt    <= 2'b00;
			owned  <= 1'b0;
			// a wins the first tie
			last_b <= 1'b1;
		end else if (!owned) begin
			if (pick_a || pick_b) begin
				gnt    <= {pick_b, pick_a};
				owned  <= 1'b1;
				last_b <= pick_b;
			end
		end else if (rel) begin
			gnt   <= 2'b00;
			owned <= 1'b0;
		end
	end

	a_one_owner: assert property (@(posedge clk) disable iff (rst) !(sel_a && sel_b))
		else $error("arbiter: both bridges selected");

	// sram response must stay with the bridge that issued it
	a_gnt_hold: assert property (@(posedge clk) disable iff (rst)
		(s.rvalid || s.bvalid) |-> owned && $onehot(gnt))
		else $error("arbiter: response pending with no grant held");

endmodule

`default_nettype wire

// ==== axi_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_sram import mem_pkg::*; #(
	parameter int    mem_words = 512,
	parameter addr_t base_addr = 32'h8000_0000
) (
	input  logic      clk,
	input  logic      rst,
	axi_lite_if.slave bus
);

	localparam int    idx_w     = (mem_words > 1) ? $clog2(mem_words) : 1;
	localparam addr_t mem_bytes = addr_t'(mem_words * word_bytes);

	typedef enum logic [1:0] {
		idle,
		read_resp,
		write_resp
	} state_t;

	state_t state;

	data_t mem [mem_words];

	// offsets from the array base
	addr_t ar_off;
	addr_t aw_off;

	logic ar_hit;
	logic aw_hit;
	logic [idx_w-1:0] ar_idx;
	logic [idx_w-1:0] aw_idx;
	logic ar_fire;
	logic aw_fire;

	assign ar_off = bus.araddr - base_addr;
	assign aw_off = bus.awaddr - base_addr;

	// inside [base_addr, base_addr + mem_bytes)
	assign ar_hit = (bus.araddr >= base_addr) && (ar_off < mem_bytes);
	assign aw_hit = (bus.awaddr >= base_addr) && (aw_off < mem_bytes);

	// low three bits dropped by the divide
	assign ar_idx = idx_w'(ar_off / word_bytes);
	assign aw_idx = idx_w'(aw_off / word_bytes);

	// read wins when both arrive together
	assign bus.arready = (state == idle);
	assign bus.awready = (state == idle) && bus.awvalid && bus.wvalid && !bus.arvalid;
	assign bus.wready  = bus.awready;

	assign ar_fire = bus.arvalid && bus.arready;
	assign aw_fire = bus.awvalid && bus.awready && bus.wvalid && bus.wready;

	// response valids come straight from the state
	assign bus.rvalid = (state == read_resp);
	assign bus.bvalid = (state == write_resp);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (ar_fire) begin
						state <= read_resp;
					end else if (aw_fire) begin
						state <= write_resp;
					end
				end
				read_resp: begin
					if (bus.rready) begin
						state <= idle;
					end
				end
				write_resp: begin
					if (bus.bready) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// in-range writes merge strobed bytes on the address-transfer edge
	always_ff @(posedge clk) begin
		if (aw_fire && aw_hit) begin
			for (int i = 0; i < word_bytes; i++) begin
				if (bus.wstrb[i]) begin
					mem[aw_idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
				end
			end
		end
	end

	// response payload held through the response state
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			bus.rdata <= ar_hit ? mem[ar_idx] : '0;
			bus.rresp <= ar_hit ? resp_okay : resp_slverr;
		end
		if (aw_fire) begin
			bus.bresp <= aw_hit ? resp_okay : resp_slverr;
		end
	end

	a_r_stable: assert property (@(posedge clk) disable iff (rst)
		bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata))
		else $error("sram: read data dropped before rready");

	a_b_stable: assert property (@(posedge clk) disable iff (rst)
		bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bresp))
		else $error("sram: write response dropped before bready");

endmodule

`default_nettype wire

// ==== mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; #(
	parameter int    mem_words = 512,
	parameter addr_t base_addr = 32'h8000_0000
) (
	input  logic  clk,
	input  logic  rst,
	// client a, e.g. instruction fetch
	input  logic  a_req,
	input  logic  a_we,
	input  addr_t a_addr,
	input  data_t a_wdata,
	input  strb_t a_wstrb,
	output logic  a_busy,
	output logic  a_resp_valid,
	output data_t a_rdata,
	output logic  a_err,
	// client b, e.g. load/store
	input  logic  b_req,
	input  logic  b_we,
	input  addr_t b_addr,
	input  data_t b_wdata,
	input  strb_t b_wstrb,
	output logic  b_busy,
	output logic  b_resp_valid,
	output data_t b_rdata,
	output logic  b_err
);

	// bridge to arbiter, and arbiter to sram
	axi_lite_if bus_a ();
	axi_lite_if bus_b ();
	axi_lite_if bus_s ();

	mem_client_bridge u_bridge_a (
		.clk        (clk),
		.rst        (rst),
		.req        (a_req),
		.we         (a_we),
		.addr       (a_addr),
		.wdata      (a_wdata),
		.wstrb      (a_wstrb),
		.busy       (a_busy),
		.resp_valid (a_resp_valid),
		.rdata      (a_rdata),
		.err        (a_err),
		.bus        (bus_a)
	);

	mem_client_bridge u_bridge_b (
		.clk        (clk),
		.rst        (rst),
		.req        (b_req),
		.we         (b_we),
		.addr       (b_addr),
		.wdata      (b_wdata),
		.wstrb      (b_wstrb),
		.busy       (b_busy),
		.resp_valid (b_resp_valid),
		.rdata      (b_rdata),
		.err        (b_err),
		.bus        (bus_b)
	);

	axi_rr_arbiter u_arb (
		.clk (clk),
		.rst (rst),
		.m_a (bus_a),
		.m_b (bus_b),
		.s   (bus_s)
	);

	axi_sram #(
		.mem_words (mem_words),
		.base_addr (base_addr)
	) u_sram (
		.clk (clk),
		.rst (rst),
		.bus (bus_s)
	);

endmodule

`default_nettype wire

// ==== tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

	localparam int    mem_words      = 512;
	localparam addr_t base_addr      = 32'h8000_0000;
	localparam addr_t end_addr       = base_addr + addr_t'(mem_words * word_bytes);
	localparam int    timeout_cycles = 100;
	localparam int    n_random       = 40;
	// random traffic stays on 16 words spread over the array
	localparam int    stride         = mem_words / 16;

	// one row per access, a contended pair takes two rows with a first
	typedef struct packed {
		logic  client;
		logic  both;
		logic  first_b;
		logic  we;
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
		data_t exp_rdata;
		logic  exp_err;
	} entry_t;

	logic  clk;
	logic  rst;
	logic  a_req, a_we, a_busy, a_resp_valid, a_err;
	logic  b_req, b_we, b_busy, b_resp_valid, b_err;
	addr_t a_addr, b_addr;
	data_t a_wdata, b_wdata, a_rdata, b_rdata;
	strb_t a_wstrb, b_wstrb;

	entry_t      tbl[$];
	data_t       shadow [mem_words];
	logic        model_last_b;
	logic [31:0] lcg_state;
	int          errors;
	int          tests_run;
	int          tests_failed;
	logic        timed_out;

	mem_subsys_top #(
		.mem_words (mem_words),
		.base_addr (base_addr)
	) dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic addr_t waddr(input int idx);
		return base_addr + addr_t'(idx * word_bytes);
	endfunction

	// reference memory: byte merge on write, zero and error outside the array
	function automatic void shadow_access(input logic we, input addr_t addr, input data_t wdata,
		input strb_t wstrb, output data_t rdata, output logic err);
		int idx;
		rdata = '0;
		err = !(addr >= base_addr && addr < end_addr);
		idx = int'((addr - base_addr) / word_bytes);
		if (!err && we) begin
			for (int i = 0; i < word_bytes; i++) begin
				if (wstrb[i]) begin
					shadow[idx][i*8 +: 8] = wdata[i*8 +: 8];
				end
			end
		end else if (!err) begin
			rdata = shadow[idx];
		end
	endfunction

	function automatic entry_t make_entry(input logic client, input logic we, input addr_t addr,
		input data_t wdata, input strb_t wstrb);
		return '{client, 1'b0, 1'b0, we, addr, wdata, wstrb, '0, 1'b0};
	endfunction

	function automatic void add_single(input entry_t e);
		shadow_access(e.we, e.addr, e.wdata, e.wstrb, e.exp_rdata, e.exp_err);
		model_last_b = e.client;
		tbl.push_back(e);
	endfunction

	// a wins the tie only if b was granted last
	function automatic void add_pair(input entry_t ea, input entry_t eb);
		ea.both = 1'b1;
		eb.both = 1'b1;
		ea.first_b = !model_last_b;
		eb.first_b = !model_last_b;
		if (model_last_b) begin
			shadow_access(ea.we, ea.addr, ea.wdata, ea.wstrb, ea.exp_rdata, ea.exp_err);
			shadow_access(eb.we, eb.addr, eb.wdata, eb.wstrb, eb.exp_rdata, eb.exp_err);
		end else begin
			shadow_access(eb.we, eb.addr, eb.wdata, eb.wstrb, eb.exp_rdata, eb.exp_err);
			shadow_access(ea.we, ea.addr, ea.wdata, ea.wstrb, ea.exp_rdata, ea.exp_err);
		end
		// loser goes last, so model_last_b keeps its value
		tbl.push_back(ea);
		tbl.push_back(eb);
	endfunction

	function automatic void build_table();
		logic [31:0] r;
		logic [31:0] d_hi;
		logic [31:0] d_lo;
		// after reset b counts as granted last
		model_last_b = 1'b1;
		add_single(make_entry(0, 1, waddr(0), 64'h0123_4567_89ab_cdef, 8'hff));
		add_single(make_entry(0, 0, waddr(0), '0, '0));
		// partial strobes on word 1
		add_single(make_entry(0, 1, waddr(1), 64'hffee_ddcc_bbaa_9988, 8'hff));
		add_single(make_entry(0, 1, waddr(1), 64'h1111_2222_3333_4444, 8'h0f));
		add_single(make_entry(0, 0, waddr(1), '0, '0));
		add_single(make_entry(0, 1, waddr(1), 64'h5555_6666_7777_8888, 8'ha5));
		// low address bits ignored
		add_single(make_entry(0, 0, waddr(1) + 32'd5, '0, '0));
		// range edges, end_addr would alias word 0 without the check
		add_single(make_entry(0, 1, waddr(mem_words - 1), 64'hdead_beef_cafe_f00d, 8'hff));
		add_single(make_entry(0, 1, base_addr - 32'd8, 64'hbad0_bad0_bad0_bad0, 8'hff));
		add_single(make_entry(0, 0, base_addr - 32'd8, '0, '0));
		add_single(make_entry(0, 1, end_addr, 64'hbad1_bad1_bad1_bad1, 8'hff));
		add_single(make_entry(0, 0, end_addr, '0, '0));
		add_single(make_entry(0, 0, waddr(mem_words - 1), '0, '0));
		add_single(make_entry(0, 0, waddr(0), '0, '0));
		// contention, b goes just before so a wins the first pair
		add_single(make_entry(1, 0, waddr(1), '0, '0));
		add_pair(make_entry(0, 0, waddr(0), '0, '0),
			make_entry(1, 1, waddr(1), 64'h0f0f_0f0f_f0f0_f0f0, 8'h3c));
		add_single(make_entry(0, 0, waddr(1), '0, '0));
		add_pair(make_entry(0, 1, waddr(2), 64'h2222_aaaa_2222_aaaa, 8'hff),
			make_entry(1, 0, waddr(0), '0, '0));
		add_single(make_entry(1, 0, waddr(2), '0, '0));
		// full writes so random reads never see an unwritten word
		for (int k = 0; k < 16; k++) begin
			d_hi = lcg_next();
			d_lo = lcg_next();
			add_single(make_entry(0, 1, waddr(k * stride), {d_hi, d_lo}, 8'hff));
		end
		for (int n = 0; n < n_random; n++) begin
			r = lcg_next();
			d_hi = lcg_next();
			d_lo = lcg_next();
			add_single(make_entry(n[0], r[0], waddr(int'(r[7:4]) * stride) + addr_t'(r[10:8]),
				{d_hi, d_lo}, r[23:16]));
		end
		// write against read on one word, a wins first, then b
		add_pair(make_entry(0, 1, waddr(stride), 64'h6666_7777_8888_9999, 8'hff),
			make_entry(1, 0, waddr(stride), '0, '0));
		add_single(make_entry(0, 0, waddr(stride), '0, '0));
		add_pair(make_entry(0, 1, waddr(stride), 64'h1234_5678_9abc_def0, 8'hf0),
			make_entry(1, 0, waddr(stride), '0, '0));
		add_single(make_entry(1, 0, waddr(stride), '0, '0));
	endfunction

	task automatic drive(input entry_t e);
		if (e.client) begin
			b_req   = 1'b1;
			b_we    = e.we;
			b_addr  = e.addr;
			b_wdata = e.wdata;
			b_wstrb = e.wstrb;
		end else begin
			a_req   = 1'b1;
			a_we    = e.we;
			a_addr  = e.addr;
			a_wdata = e.wdata;
			a_wstrb = e.wstrb;
		end
	endtask

	// waits for each wanted resp_valid, keeps the cycle it came in
	task automatic collect(input logic want_a, input logic want_b, output logic ok,
		output int t_a, output int t_b, output data_t rd_a, output logic er_a,
		output data_t rd_b, output logic er_b);
		logic done_a;
		logic done_b;
		int   cyc;
		done_a = !want_a;
		done_b = !want_b;
		cyc = 0;
		t_a = 0;
		t_b = 0;
		while (!(done_a && done_b) && cyc < timeout_cycles) begin
			@(posedge clk);
			#1;
			cyc++;
			if (!done_a && a_resp_valid) begin
				done_a = 1'b1;
				t_a = cyc;
				rd_a = a_rdata;
				er_a = a_err;
			end
			if (!done_b && b_resp_valid) begin
				done_b = 1'b1;
				t_b = cyc;
				rd_b = b_rdata;
				er_b = b_err;
			end
			// busy drops together with resp_valid
			if ((a_resp_valid && a_busy) || (b_resp_valid && b_busy)) begin
				$display("[ERROR] %0t: busy still high with resp_valid", $time);
				errors++;
			end
		end
		ok = done_a && done_b;
	endtask

	task automatic check_result(input int idx, input data_t rd, input logic er,
		input logic order_ok);
		entry_t e;
		logic   bad;
		e = tbl[idx];
		bad = !order_ok;
		if (rd !== e.exp_rdata) begin
			$display("[ERROR] %0t: test %0d rdata %h, expected %h", $time, idx, rd, e.exp_rdata);
			errors++;
			bad = 1'b1;
		end
		if (er !== e.exp_err) begin
			$display("[ERROR] %0t: test %0d err %b, expected %b", $time, idx, er, e.exp_err);
			errors++;
			bad = 1'b1;
		end
		tests_run++;
		if (bad) begin
			tests_failed++;
		end
		$display("test %0d: client %s %s %h %s", idx, e.client ? "b" : "a",
			e.we ? "write" : "read", e.addr, bad ? "failed" : "ok");
	endtask

	task automatic run_entry(input int idx);
		int    ia;
		int    ib;
		int    t_a;
		int    t_b;
		logic  ok;
		logic  order_ok;
		data_t rd_a;
		data_t rd_b;
		logic  er_a;
		logic  er_b;
		ia = (tbl[idx].both || !tbl[idx].client) ? idx : -1;
		ib = tbl[idx].both ? idx + 1 : (tbl[idx].client ? idx : -1);
		if (ia >= 0) begin
			drive(tbl[ia]);
		end
		if (ib >= 0) begin
			drive(tbl[ib]);
		end
		@(posedge clk);
		#1;
		a_req = 1'b0;
		b_req = 1'b0;
		if ((ia >= 0 && !a_busy) || (ib >= 0 && !b_busy)) begin
			$display("[ERROR] %0t: test %0d busy not raised after req", $time, idx);
			errors++;
		end
		collect(ia >= 0, ib >= 0, ok, t_a, t_b, rd_a, er_a, rd_b, er_b);
		if (!ok) begin
			$display("timeout: the DUT gave no response within %0d cycles on test %0d",
				timeout_cycles, idx);
			timed_out = 1'b1;
			tests_failed++;
		end else begin
			order_ok = 1'b1;
			if (tbl[idx].both && (tbl[idx].first_b ? (t_b >= t_a) : (t_a >= t_b))) begin
				$display("[ERROR] %0t: test %0d client %s should respond first", $time, idx,
					tbl[idx].first_b ? "b" : "a");
				errors++;
				order_ok = 1'b0;
			end
			if (ia >= 0) begin
				check_result(ia, rd_a, er_a, order_ok);
			end
			if (ib >= 0) begin
				check_result(ib, rd_b, er_b, order_ok);
			end
		end
	endtask

	initial begin
		int i;
		rst = 1'b1;
		a_req = 1'b0;
		a_we = 1'b0;
		a_addr = '0;
		a_wdata = '0;
		a_wstrb = '0;
		b_req = 1'b0;
		b_we = 1'b0;
		b_addr = '0;
		b_wdata = '0;
		b_wstrb = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		lcg_state = 32'h3bc4;
		build_table();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		// idle outputs straight after reset
		tests_run++;
		if (a_busy || b_busy || a_resp_valid || b_resp_valid) begin
			$display("[ERROR] %0t: busy or resp_valid high after reset", $time);
			errors++;
			tests_failed++;
		end
		$display("test reset: %s", (errors == 0) ? "ok" : "failed");
		i = 0;
		while (i < tbl.size() && !timed_out) begin
			run_entry(i);
			i += tbl[i].both ? 2 : 1;
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
mem_pkg.sv
axi_lite_if.sv
mem_client_bridge.sv
axi_rr_arbiter.sv
axi_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - mem_pkg.sv
  - axi_lite_if.sv
  - mem_client_bridge.sv
  - axi_rr_arbiter.sv
  - axi_sram.sv
  - mem_subsys_top.sv
  - target: test
    files:
      - tb_mem_subsys.sv
